// ==== design/hl_cmd_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "hl_ctrl_cfg.svh"

module hl_cmd_regs (
  input  logic                  clk_ctrl,
  input  logic                  rst_n_i,

  // command from the sync stage
  input  logic                  cmd_rqst_i,
  input  logic                  cmd_ptt_i,
  input  hl_ctrl_pkg::cmd_addr_t cmd_addr_i,
  input  hl_ctrl_pkg::cmd_data_t cmd_data_i,

  // control outputs
  output logic                  tx_on_o,
  output logic                  pa_en_o,
  output logic                  rffe_rfsw_sel_o,
  output hl_ctrl_pkg::pga_t     rffe_ad9866_pga_o,

  // readback of the addressed register
  output hl_ctrl_pkg::cmd_data_t rdata_o
);

  localparam int WD_CYCLES = `HL_WATCHDOG_CYCLES;
  localparam int WD_W      = $clog2(WD_CYCLES + 1);

  logic            wr_ctrl;
  logic            wr_pga;
  logic [WD_W-1:0] wd_cnt_q;
  logic            wd_expire;

  ////////////////////
  // write decode

  assign wr_ctrl = cmd_rqst_i && (cmd_addr_i == `HL_ADDR_CTRL);
  assign wr_pga  = cmd_rqst_i && (cmd_addr_i == `HL_ADDR_PGA);

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pa_en_o           <= 1'b0;
      rffe_rfsw_sel_o   <= 1'b0;
      rffe_ad9866_pga_o <= '0;
    end else begin
      if (wr_ctrl) begin
        pa_en_o         <= cmd_data_i[0];
        rffe_rfsw_sel_o <= cmd_data_i[1];
      end
      if (wr_pga) begin
        rffe_ad9866_pga_o <= cmd_data_i[hl_ctrl_pkg::PGA_W-1:0];
      end
    end
  end

  ////////////////////
  // tx watchdog

  // counter saturates at WD_CYCLES, every command restarts it
  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wd_cnt_q <= '0;
    end else if (cmd_rqst_i) begin
      wd_cnt_q <= '0;
    end else if (wd_cnt_q != WD_W'(WD_CYCLES)) begin
      wd_cnt_q <= wd_cnt_q + WD_W'(1);
    end
  end

  // counter reaches WD_CYCLES on this edge
  assign wd_expire = (wd_cnt_q == WD_W'(WD_CYCLES - 1));

  // ptt from every command, dropped when the host goes quiet
  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_on_o <= 1'b0;
    end else if (cmd_rqst_i) begin
      tx_on_o <= cmd_ptt_i;
    end else if (wd_expire && tx_on_o) begin
      tx_on_o <= 1'b0;
    end
  end

  ////////////////////
  // readback

  // zero extended, unknown addresses read 0
  always_comb begin
    rdata_o = '0;
    case (cmd_addr_i)
      `HL_ADDR_CTRL: begin
        rdata_o[0] = pa_en_o;
        rdata_o[1] = rffe_rfsw_sel_o;
      end
      `HL_ADDR_PGA: begin
        rdata_o[hl_ctrl_pkg::PGA_W-1:0] = rffe_ad9866_pga_o;
      end
      default: begin
        rdata_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/hl_cmd_sync.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "hl_ctrl_cfg.svh"

module hl_cmd_sync (
  input  logic clk_ctrl,
  input  logic rst_n_i,

  // async inputs
  input  logic cmd_cnt_i,
  input  logic rxclip_i,
  input  logic rxgoodlvl_i,

  // clk_ctrl domain
  output logic cmd_rqst_o,
  output logic rxclip_o,
  output logic rxgoodlvl_o
);

  localparam int DEPTH   = `HL_SYNC_DEPTH;

  // bit positions inside each synchronizer stage
  localparam int CNT_BIT  = 0;
  localparam int CLIP_BIT = 1;
  localparam int GOOD_BIT = 2;

  ////////////////////
  // synchronizer chains

  // stage 0 is the first flop, stage DEPTH-1 the output
  logic [DEPTH-1:0][2:0] sync_q;
  logic [2:0]            async_in;

  // previous synchronized toggle level
  logic                  cnt_prev_q;

  assign async_in[CNT_BIT]  = cmd_cnt_i;
  assign async_in[CLIP_BIT] = rxclip_i;
  assign async_in[GOOD_BIT] = rxgoodlvl_i;

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q     <= '0;
      cnt_prev_q <= 1'b0;
    end else begin
      sync_q     <= {sync_q[DEPTH-2:0], async_in};
      cnt_prev_q <= sync_q[DEPTH-1][CNT_BIT];
    end
  end

  ////////////////////
  // outputs

  // any change of the toggle level is one command
  assign cmd_rqst_o  = sync_q[DEPTH-1][CNT_BIT] ^ cnt_prev_q;

  assign rxclip_o    = sync_q[DEPTH-1][CLIP_BIT];
  assign rxgoodlvl_o = sync_q[DEPTH-1][GOOD_BIT];

endmodule

`default_nettype wire

// ==== design/hl_ctrl_cfg.svh ====
`ifndef HL_CTRL_CFG_SVH
`define HL_CTRL_CFG_SVH

////////////////////
// command addresses

// control register: bit 0 PA enable, bit 1 RF switch select
`define HL_ADDR_CTRL 6'h00

// AD9866 PGA register: bits 5..0 gain code
`define HL_ADDR_PGA 6'h0A

////////////////////
// synchronizers

// flops per async input chain
`define HL_SYNC_DEPTH 2

////////////////////
// transmit watchdog

// clk_ctrl cycles without a command before tx is dropped
`define HL_WATCHDOG_CYCLES 200

`endif

// ==== design/hl_ctrl_pkg.sv ====
`default_nettype none

package hl_ctrl_pkg;

  ////////////////////
  // field widths

  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;
  localparam int PGA_W      = 6;
  localparam int LED_W      = 4;

  // sticky clip, sticky good level, address echo, readback
  localparam int RESP_W     = 2 + CMD_ADDR_W + CMD_DATA_W;

  ////////////////////
  // types

  // command register address
  typedef logic [CMD_ADDR_W-1:0] cmd_addr_t;

  // command payload
  typedef logic [CMD_DATA_W-1:0] cmd_data_t;

  // response word, see hl_resp_gen for the field order
  typedef logic [RESP_W-1:0]     resp_t;

  // AD9866 PGA gain code
  typedef logic [PGA_W-1:0]      pga_t;

  // LED bank
  typedef logic [LED_W-1:0]      led_t;

endpackage

`default_nettype wire

// ==== design/hl_ctrl_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module hl_ctrl_top (
  input  logic                   clk_ctrl,
  input  logic                   rst_n_i,

  // host command, toggle plus stable fields
  input  logic                   cmd_cnt_i,
  input  hl_ctrl_pkg::cmd_addr_t cmd_addr_i,
  input  hl_ctrl_pkg::cmd_data_t cmd_data_i,
  input  logic                   cmd_ptt_i,
  input  logic                   cmd_resp_i,

  // receiver level flags, async
  input  logic                   rxclip_i,
  input  logic                   rxgoodlvl_i,

  // control outputs
  output logic                   tx_on_o,
  output logic                   pa_en_o,
  output logic                   rffe_rfsw_sel_o,
  output hl_ctrl_pkg::pga_t      rffe_ad9866_pga_o,

  // response and LEDs
  output hl_ctrl_pkg::resp_t     resp_o,
  output logic                   resp_rqst_o,
  output hl_ctrl_pkg::led_t      io_led_o
);

  logic                   cmd_rqst;
  logic                   rxclip_s;
  logic                   rxgoodlvl_s;
  hl_ctrl_pkg::cmd_data_t rdata;

  ////////////////////
  // input sync

  hl_cmd_sync u_cmd_sync (
    .clk_ctrl    (clk_ctrl),
    .rst_n_i     (rst_n_i),
    .cmd_cnt_i   (cmd_cnt_i),
    .rxclip_i    (rxclip_i),
    .rxgoodlvl_i (rxgoodlvl_i),
    .cmd_rqst_o  (cmd_rqst),
    .rxclip_o    (rxclip_s),
    .rxgoodlvl_o (rxgoodlvl_s)
  );

  ////////////////////
  // control registers

  hl_cmd_regs u_cmd_regs (
    .clk_ctrl          (clk_ctrl),
    .rst_n_i           (rst_n_i),
    .cmd_rqst_i        (cmd_rqst),
    .cmd_ptt_i         (cmd_ptt_i),
    .cmd_addr_i        (cmd_addr_i),
    .cmd_data_i        (cmd_data_i),
    .tx_on_o           (tx_on_o),
    .pa_en_o           (pa_en_o),
    .rffe_rfsw_sel_o   (rffe_rfsw_sel_o),
    .rffe_ad9866_pga_o (rffe_ad9866_pga_o),
    .rdata_o           (rdata)
  );

  ////////////////////
  // response

  hl_resp_gen u_resp_gen (
    .clk_ctrl    (clk_ctrl),
    .rst_n_i     (rst_n_i),
    .cmd_rqst_i  (cmd_rqst),
    .cmd_resp_i  (cmd_resp_i),
    .rxclip_i    (rxclip_s),
    .rxgoodlvl_i (rxgoodlvl_s),
    .tx_on_i     (tx_on_o),
    .pa_en_i     (pa_en_o),
    .cmd_addr_i  (cmd_addr_i),
    .rdata_i     (rdata),
    .resp_o      (resp_o),
    .resp_rqst_o (resp_rqst_o),
    .io_led_o    (io_led_o)
  );

endmodule

`default_nettype wire

// ==== design/hl_resp_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module hl_resp_gen (
  input  logic                   clk_ctrl,
  input  logic                   rst_n_i,

  // command and status
  input  logic                   cmd_rqst_i,
  input  logic                   cmd_resp_i,
  input  logic                   rxclip_i,
  input  logic                   rxgoodlvl_i,
  input  logic                   tx_on_i,
  input  logic                   pa_en_i,
  input  hl_ctrl_pkg::cmd_addr_t cmd_addr_i,
  input  hl_ctrl_pkg::cmd_data_t rdata_i,

  // response to the host
  output hl_ctrl_pkg::resp_t     resp_o,
  output logic                   resp_rqst_o,

  // front panel
  output hl_ctrl_pkg::led_t      io_led_o
);

  // response owed, waits one cycle for the register write
  logic resp_pend_q;

  // sticky status since the last response
  logic clip_sticky_q;
  logic good_sticky_q;

  ////////////////////
  // request delay

  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_pend_q <= 1'b0;
      resp_rqst_o <= 1'b0;
    end else begin
      resp_pend_q <= cmd_rqst_i & cmd_resp_i;
      resp_rqst_o <= resp_pend_q;
    end
  end

  ////////////////////
  // sticky bits

  // a level seen in the clear cycle keeps the bit set
  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      clip_sticky_q <= 1'b0;
      good_sticky_q <= 1'b0;
    end else begin
      clip_sticky_q <= rxclip_i | (clip_sticky_q & ~resp_pend_q);
      good_sticky_q <= rxgoodlvl_i | (good_sticky_q & ~resp_pend_q);
    end
  end

  ////////////////////
  // response word

  // sticky bits, address echo, post-write readback
  always_ff @(posedge clk_ctrl or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_o <= '0;
    end else if (resp_pend_q) begin
      resp_o <= {clip_sticky_q, good_sticky_q, cmd_addr_i, rdata_i};
    end
  end

  // tx, pa, clip, good level from msb down
  assign io_led_o = {tx_on_i, pa_en_i, clip_sticky_q, good_sticky_q};

endmodule

`default_nettype wire

// ==== hl_ctrl_top.f ====
+incdir+design
design/hl_ctrl_pkg.sv
design/hl_cmd_sync.sv
design/hl_cmd_regs.sv
design/hl_resp_gen.sv
design/hl_ctrl_top.sv
testbench/hl_ctrl_assertions.sv
testbench/hl_ctrl_tb.sv

// ==== testbench/hl_ctrl_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module hl_ctrl_assertions (
  input logic clk_ctrl,
  input logic rst_n_i,
  input logic resp_rqst_i,
  input logic tx_on_i
);

  // failures per assertion
  int unsigned rqst_fail_cnt  = 0;
  int unsigned reset_fail_cnt = 0;

  ////////////////////
  // response pulse

  // response request lasts exactly one cycle
  resp_single_cycle: assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    resp_rqst_i |=> !resp_rqst_i)
  else begin
    $error("resp_rqst_o high for two consecutive cycles");
    rqst_fail_cnt++;
  end

  ////////////////////
  // reset

  tx_off_in_reset: assert property (@(posedge clk_ctrl)
    !rst_n_i |-> (!tx_on_i && !resp_rqst_i))
  else begin
    $error("tx_on_o or resp_rqst_o high during reset");
    reset_fail_cnt++;
  end

endmodule

bind hl_ctrl_top hl_ctrl_assertions u_assertions (
  .clk_ctrl    (clk_ctrl),
  .rst_n_i     (rst_n_i),
  .resp_rqst_i (resp_rqst_o),
  .tx_on_i     (tx_on_o)
);

`default_nettype wire

// ==== testbench/hl_ctrl_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "hl_ctrl_cfg.svh"

module hl_ctrl_tb;

  localparam int CLK_PERIOD     = 8;
  localparam int NUM_CMDS       = 80;
  // field setup, five check cycles, longest gap, status pulse
  localparam int MAX_CMD_CYCLES = 16;
  localparam int TIMEOUT_NS     =
    (NUM_CMDS * MAX_CMD_CYCLES + `HL_WATCHDOG_CYCLES + 200) * CLK_PERIOD;

  logic                   clk_ctrl = 1'b0;
  logic                   rst_n_i;
  logic                   cmd_cnt_i;
  hl_ctrl_pkg::cmd_addr_t cmd_addr_i;
  hl_ctrl_pkg::cmd_data_t cmd_data_i;
  logic                   cmd_ptt_i;
  logic                   cmd_resp_i;
  logic                   rxclip_i;
  logic                   rxgoodlvl_i;
  logic                   tx_on_o;
  logic                   pa_en_o;
  logic                   rffe_rfsw_sel_o;
  hl_ctrl_pkg::pga_t      rffe_ad9866_pga_o;
  hl_ctrl_pkg::resp_t     resp_o;
  logic                   resp_rqst_o;
  hl_ctrl_pkg::led_t      io_led_o;

  // reference model state
  logic                   pa_m;
  logic                   rfsw_m;
  hl_ctrl_pkg::pga_t      pga_m;
  logic                   tx_m;
  logic                   clip_m;
  logic                   good_m;
  hl_ctrl_pkg::resp_t     resp_m;
  logic [31:0]            rng_state = 32'hb6da;

  hl_ctrl_top u_dut (.*);

  always #(CLK_PERIOD / 2) clk_ctrl = ~clk_ctrl;

  ////////////////////
  // helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // register contents as the host reads them back
  function automatic hl_ctrl_pkg::cmd_data_t expected_readback(input logic [5:0] addr);
    if (addr == `HL_ADDR_CTRL) begin
      return {30'd0, rfsw_m, pa_m};
    end else if (addr == `HL_ADDR_PGA) begin
      return {26'd0, pga_m};
    end
    return '0;
  endfunction

  task automatic check_value(input string name, input logic [39:0] actual,
                             input logic [39:0] expected);
    assert (actual === expected) else begin
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_outputs();
    check_value("pa_en_o", 40'(pa_en_o), 40'(pa_m));
    check_value("rffe_rfsw_sel_o", 40'(rffe_rfsw_sel_o), 40'(rfsw_m));
    check_value("rffe_ad9866_pga_o", 40'(rffe_ad9866_pga_o), 40'(pga_m));
    check_value("tx_on_o", 40'(tx_on_o), 40'(tx_m));
    check_value("io_led_o", 40'(io_led_o), 40'({tx_m, pa_m, clip_m, good_m}));
    check_value("resp_o", 40'(resp_o), 40'(resp_m));
  endtask

  // one command from toggle to the cycle after the response slot
  task automatic run_command(input logic [5:0] addr, input logic [31:0] data,
                             input logic ptt, input logic resp);
    hl_ctrl_pkg::resp_t resp_exp;
    cmd_addr_i = addr;
    cmd_data_i = data;
    cmd_ptt_i  = ptt;
    cmd_resp_i = resp;
    @(negedge clk_ctrl);
    cmd_cnt_i = ~cmd_cnt_i;
    @(negedge clk_ctrl);
    check_value("resp_rqst_o", 40'(resp_rqst_o), 40'd0);
    // still in the sync chain with nothing applied yet
    @(negedge clk_ctrl);
    check_outputs();
    check_value("resp_rqst_o", 40'(resp_rqst_o), 40'd0);
    if (addr == `HL_ADDR_CTRL) begin
      pa_m   = data[0];
      rfsw_m = data[1];
    end else if (addr == `HL_ADDR_PGA) begin
      pga_m = data[5:0];
    end
    tx_m = ptt;
    @(negedge clk_ctrl);
    check_outputs();
    check_value("resp_rqst_o", 40'(resp_rqst_o), 40'd0);
    resp_exp = {clip_m, good_m, addr, expected_readback(addr)};
    @(negedge clk_ctrl);
    check_value("resp_rqst_o", 40'(resp_rqst_o), 40'(resp));
    if (resp) begin
      resp_m = resp_exp;
      clip_m = 1'b0;
      good_m = 1'b0;
    end
    check_outputs();
    @(negedge clk_ctrl);
    check_value("resp_rqst_o", 40'(resp_rqst_o), 40'd0);
  endtask

  task automatic pulse_status(input logic clip, input logic good);
    rxclip_i    = clip;
    rxgoodlvl_i = good;
    repeat (2) @(negedge clk_ctrl);
    rxclip_i    = 1'b0;
    rxgoodlvl_i = 1'b0;
    repeat (3) @(negedge clk_ctrl);
    clip_m = clip_m | clip;
    good_m = good_m | good;
    check_outputs();
  endtask

  ////////////////////
  // timeout

  initial begin
    #(TIMEOUT_NS);
    $display("[ERROR] %0t ns run did not finish within the expected time", $time);
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

  ////////////////////
  // stimulus

  initial begin
    logic [31:0] r;
    logic [5:0]  addr;
    int unsigned bound_fails;
    rst_n_i     = 1'b0;
    cmd_cnt_i   = 1'b0;
    cmd_addr_i  = '0;
    cmd_data_i  = '0;
    cmd_ptt_i   = 1'b0;
    cmd_resp_i  = 1'b0;
    rxclip_i    = 1'b0;
    rxgoodlvl_i = 1'b0;
    pa_m   = 1'b0;
    rfsw_m = 1'b0;
    pga_m  = '0;
    tx_m   = 1'b0;
    clip_m = 1'b0;
    good_m = 1'b0;
    resp_m = '0;
    repeat (5) @(negedge clk_ctrl);
    rst_n_i = 1'b1;

    // quiet outputs after reset
    repeat (4) begin
      @(negedge clk_ctrl);
      check_outputs();
      check_value("resp_rqst_o", 40'(resp_rqst_o), 40'd0);
    end

    for (int i = 0; i < NUM_CMDS; i++) begin
      rng_state = xorshift32(rng_state);
      r = rng_state;
      case (r[1:0])
        2'd0:    addr = `HL_ADDR_CTRL;
        2'd1:    addr = `HL_ADDR_PGA;
        2'd2:    addr = r[12] ? `HL_ADDR_CTRL : `HL_ADDR_PGA;
        default: addr = r[21:16];
      endcase
      rng_state = xorshift32(rng_state);
      run_command(addr, rng_state, r[2], r[3]);
      repeat (2 + int'(r[6:5])) @(negedge clk_ctrl);
      if (r[9:8] == 2'd0) begin
        pulse_status(r[10] | ~r[11], r[11]);
      end
    end

    // tx watchdog with ptt on and then silence
    run_command(`HL_ADDR_CTRL, 32'h1, 1'b1, 1'b0);
    repeat (188) @(negedge clk_ctrl);
    check_value("tx_on_o", 40'(tx_on_o), 40'd1);
    repeat (20) @(negedge clk_ctrl);
    tx_m = 1'b0;
    check_outputs();

    bound_fails = u_dut.u_assertions.rqst_fail_cnt + u_dut.u_assertions.reset_fail_cnt;
    if (bound_fails == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("[ERROR] %0t ns bound assertions failed %0d times", $time, bound_fails);
      $display("TB FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire
